//--- include/mini_mcu_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu address map, memory size and GPIO width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MINI_MCU_MACROS_SVH
`define MINI_MCU_MACROS_SVH

// word RAM, 1 KiB
`define RAM_WORDS 256
`define RAM_IDX_W 8

// region select on addr[31:16]
`define REGION_RAM      16'h0000
`define REGION_GPIO     16'h2000
`define REGION_SOC_CTRL 16'h2001

`define GPIO_WIDTH 32

// returned for reads that hit no target
`define UNMAPPED_RDATA 32'hDEADBEEF

`endif

//--- logic/mini_mcu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu shared types: bus words, RAM index, GPIO vector, bus FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mini_mcu_macros.svh"

package mini_mcu_pkg;

  // byte address and data word on the bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  typedef logic [`RAM_IDX_W-1:0] ram_idx_t;

  // one bit per GPIO line
  typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

  // access takes one cycle in each of ACCESS and RESPOND
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACCESS,
    BUS_RESPOND
  } bus_state_t;

endpackage

//--- logic/bus_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus controller: accepts one access at a time, decodes the region,
// strobes the target and returns the response two cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module bus_controller
  import mini_mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  bus_req_i,
  input  logic  bus_we_i,
  input  addr_t bus_addr_i,
  input  word_t bus_wdata_i,
  input  word_t ram_rdata_i,
  input  word_t gpio_rdata_i,
  input  word_t soc_rdata_i,
  output logic  ram_sel_o,
  output logic  gpio_sel_o,
  output logic  soc_sel_o,
  output logic  tgt_we_o,
  output addr_t tgt_addr_o,
  output word_t tgt_wdata_o,
  output logic  bus_rvalid_o,
  output word_t bus_rdata_o
);

  localparam logic [1:0] RGN_NONE = 2'd0;
  localparam logic [1:0] RGN_RAM  = 2'd1;
  localparam logic [1:0] RGN_GPIO = 2'd2;
  localparam logic [1:0] RGN_SOC  = 2'd3;

  bus_state_t state_q;
  logic [1:0] region_d;
  logic [1:0] region_q;
  logic       accept;
  word_t      resp_rdata;

  // requests outside IDLE are dropped
  assign accept = bus_req_i && (state_q == BUS_IDLE);

  always_comb begin
    case (bus_addr_i[31:16])
      `REGION_RAM:      region_d = RGN_RAM;
      `REGION_GPIO:     region_d = RGN_GPIO;
      `REGION_SOC_CTRL: region_d = RGN_SOC;
      default:          region_d = RGN_NONE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= BUS_IDLE;
      ram_sel_o    <= 1'b0;
      gpio_sel_o   <= 1'b0;
      soc_sel_o    <= 1'b0;
      bus_rvalid_o <= 1'b0;
    end else begin
      // one-cycle strobes, none when unmapped
      ram_sel_o    <= accept && (region_d == RGN_RAM);
      gpio_sel_o   <= accept && (region_d == RGN_GPIO);
      soc_sel_o    <= accept && (region_d == RGN_SOC);
      bus_rvalid_o <= (state_q == BUS_RESPOND);
      case (state_q)
        BUS_IDLE:    if (accept) state_q <= BUS_ACCESS;
        BUS_ACCESS:  state_q <= BUS_RESPOND;
        BUS_RESPOND: state_q <= BUS_IDLE;
        default:     state_q <= BUS_IDLE;
      endcase
    end
  end

  // request fields held for the target and the response mux
  always_ff @(posedge clk_i) begin
    if (accept) begin
      region_q    <= region_d;
      tgt_we_o    <= bus_we_i;
      tgt_addr_o  <= bus_addr_i;
      tgt_wdata_o <= bus_wdata_i;
    end
  end

  always_comb begin
    if (tgt_we_o) begin
      resp_rdata = '0;
    end else begin
      case (region_q)
        RGN_RAM:  resp_rdata = ram_rdata_i;
        RGN_GPIO: resp_rdata = gpio_rdata_i;
        RGN_SOC:  resp_rdata = soc_rdata_i;
        default:  resp_rdata = `UNMAPPED_RDATA;
      endcase
    end
  end

  // target read word is registered by now
  always_ff @(posedge clk_i) begin
    if (state_q == BUS_RESPOND) begin
      bus_rdata_o <= resp_rdata;
    end
  end

endmodule

//--- logic/ram_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port word RAM with registered read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module ram_bank
  import mini_mcu_pkg::*;
(
  input  logic     clk_i,
  input  logic     sel_i,
  input  logic     we_i,
  input  ram_idx_t idx_i,
  input  word_t    wdata_i,
  output word_t    rdata_o
);

  word_t mem_q [`RAM_WORDS];

  // read data only updates on a read select
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        mem_q[idx_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

//--- logic/gpio_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO unit: output and enable registers, synchronized input, reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module gpio_unit
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      sel_i,
  input  logic      we_i,
  input  logic [1:0] offset_i,
  input  word_t     wdata_i,
  output word_t     rdata_o,
  input  gpio_vec_t gpio_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_en_o
);

  gpio_vec_t sync_q1;
  gpio_vec_t sync_q2;

  // offset 0 output, 1 enable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_o    <= '0;
      gpio_en_o <= '0;
    end else if (sel_i && we_i) begin
      case (offset_i)
        2'd0:    gpio_o    <= wdata_i[`GPIO_WIDTH-1:0];
        2'd1:    gpio_en_o <= wdata_i[`GPIO_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    sync_q1 <= gpio_i;
    sync_q2 <= sync_q1;
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      case (offset_i)
        2'd0:    rdata_o <= word_t'(gpio_o);
        2'd1:    rdata_o <= word_t'(gpio_en_o);
        2'd2:    rdata_o <= word_t'(sync_q2);
        default: rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/soc_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC control: program exit value and sticky exit flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_ctrl
  import mini_mcu_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       sel_i,
  input  logic       we_i,
  input  logic [1:0] offset_i,
  input  word_t      wdata_i,
  output word_t      rdata_o,
  output word_t      exit_value_o,
  output logic       exit_valid_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else if (sel_i && we_i) begin
      if (offset_i == 2'd0) begin
        exit_value_o <= wdata_i;
      end
      // flag only ever sets, reset clears it
      if (offset_i == 2'd1 && wdata_i[0]) begin
        exit_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      case (offset_i)
        2'd0:    rdata_o <= exit_value_o;
        2'd1:    rdata_o <= {31'b0, exit_valid_o};
        default: rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/mini_mcu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu top: bus controller routing the master port to RAM, GPIO and
// SoC control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  addr_t     bus_addr_i,
  input  word_t     bus_wdata_i,
  output logic      bus_rvalid_o,
  output word_t     bus_rdata_o,

  input  gpio_vec_t gpio_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_en_o,

  output word_t     exit_value_o,
  output logic      exit_valid_o
);

  // controller to target signals
  logic  ram_sel;
  logic  gpio_sel;
  logic  soc_sel;
  logic  tgt_we;
  addr_t tgt_addr;
  word_t tgt_wdata;

  word_t ram_rdata;
  word_t gpio_rdata;
  word_t soc_rdata;

  bus_controller bus_controller_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .soc_rdata_i  (soc_rdata),
    .ram_sel_o    (ram_sel),
    .gpio_sel_o   (gpio_sel),
    .soc_sel_o    (soc_sel),
    .tgt_we_o     (tgt_we),
    .tgt_addr_o   (tgt_addr),
    .tgt_wdata_o  (tgt_wdata),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o)
  );

  ram_bank ram_bank_i (
    .clk_i   (clk_i),
    .sel_i   (ram_sel),
    .we_i    (tgt_we),
    .idx_i   (tgt_addr[`RAM_IDX_W+1:2]),
    .wdata_i (tgt_wdata),
    .rdata_o (ram_rdata)
  );

  gpio_unit gpio_unit_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_i     (gpio_sel),
    .we_i      (tgt_we),
    .offset_i  (tgt_addr[3:2]),
    .wdata_i   (tgt_wdata),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .sel_i        (soc_sel),
    .we_i         (tgt_we),
    .offset_i     (tgt_addr[3:2]),
    .wdata_i      (tgt_wdata),
    .rdata_o      (soc_rdata),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

//--- sim/mini_mcu_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu checks: response timing, single-cycle pulse, sticky exit flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mini_mcu_assert
  import mini_mcu_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      bus_req_i,
  input logic      bus_rvalid_i,
  input logic      ram_sel_i,
  input logic      gpio_sel_i,
  input logic      soc_sel_i,
  input gpio_vec_t gpio_out_i,
  input gpio_vec_t gpio_en_i,
  input word_t     exit_value_i,
  input logic      exit_valid_i
);

  logic [1:0]  busy_cnt_q;
  logic        accept;
  int unsigned fail_cnt = 0;

  // bus is busy for two edges after an accepted request
  assign accept = bus_req_i && (busy_cnt_q == 2'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_cnt_q <= 2'd0;
    end else if (accept) begin
      busy_cnt_q <= 2'd2;
    end else if (busy_cnt_q != 2'd0) begin
      busy_cnt_q <= busy_cnt_q - 2'd1;
    end
  end

  // pulse is registered at the second edge after acceptance
  resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(accept, 3) |-> bus_rvalid_i)
    else begin
      $error("no response two cycles after an accepted request");
      fail_cnt++;
    end

  resp_single: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_rvalid_i |-> !$past(bus_rvalid_i))
    else begin
      $error("response pulse longer than one cycle");
      fail_cnt++;
    end

  exit_sticky: assert property (@(posedge clk_i)
    ($past(exit_valid_i) && !$past(reset_i)) |-> exit_valid_i)
    else begin
      $error("exit flag fell without reset");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk_i)
    ($past(reset_i) && !reset_i) |-> (!bus_rvalid_i && !ram_sel_i && !gpio_sel_i
      && !soc_sel_i && gpio_out_i == '0 && gpio_en_i == '0 && exit_value_i == '0
      && !exit_valid_i))
    else begin
      $error("outputs or strobes not low after reset");
      fail_cnt++;
    end

endmodule

bind mini_mcu mini_mcu_assert assert_i (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .bus_req_i    (bus_req_i),
  .bus_rvalid_i (bus_rvalid_o),
  .ram_sel_i    (ram_sel),
  .gpio_sel_i   (gpio_sel),
  .soc_sel_i    (soc_sel),
  .gpio_out_i   (gpio_o),
  .gpio_en_i    (gpio_en_o),
  .exit_value_i (exit_value_o),
  .exit_valid_i (exit_valid_o)
);

//--- sim/tb_mini_mcu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu testbench covering RAM, GPIO, SoC control, unmapped and busy
// accesses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int RESP_WAIT  = 8;
  // cycle budgets of the reset, ram, gpio, unmapped, exit and busy tests
  localparam int BUDGET = 16 + 64 * 5 + 60 + 30 + 40 + 40;
  localparam int WATCHDOG_NS = BUDGET * 2 * CLK_PERIOD;

  logic      clk_i;
  logic      reset_i;
  logic      bus_req_i;
  logic      bus_we_i;
  addr_t     bus_addr_i;
  word_t     bus_wdata_i;
  logic      bus_rvalid_o;
  word_t     bus_rdata_o;
  gpio_vec_t gpio_i;
  gpio_vec_t gpio_o;
  gpio_vec_t gpio_en_o;
  word_t     exit_value_o;
  logic      exit_valid_o;

  word_t    ram_model [`RAM_WORDS];
  ram_idx_t written_q [$];
  word_t    gpio_out_exp;
  word_t    gpio_en_exp;
  string    test_name;
  int       err_cnt;
  int       test_err_base;
  int       tests_run;
  int       tests_failed;

  mini_mcu UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic addr_t ram_addr(input ram_idx_t idx);
    return {`REGION_RAM, 16'h0000} | (addr_t'(idx) << 2);
  endfunction

  task automatic compare_word(input word_t expected, input word_t actual);
    assert (actual == expected) else begin
      $display("FAILED %s: expected %08h, actual %08h", test_name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_base = err_cnt;
    tests_run++;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_base) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: fail, %0d mismatches", test_name, err_cnt - test_err_base);
      tests_failed++;
    end
  endtask

  // one strobe, then wait for the response pulse
  task automatic bus_access(input logic we, input addr_t addr, input word_t wdata,
                            output word_t rdata);
    int wait_cnt;
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    bus_req_i = 1'b0;
    wait_cnt  = 0;
    while (!bus_rvalid_o && wait_cnt < RESP_WAIT) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    assert (bus_rvalid_o) else begin
      $display("%s: no response for address %08h within %0d cycles", test_name, addr,
               RESP_WAIT);
      err_cnt++;
    end
    rdata = bus_rdata_o;
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    compare_word(32'h0, word_t'(bus_rvalid_o));
    compare_word(32'h0, word_t'(gpio_o));
    compare_word(32'h0, word_t'(gpio_en_o));
    compare_word(32'h0, word_t'(exit_valid_o));
    compare_word(32'h0, exit_value_o);
    end_test();
  endtask

  task automatic ram_readback();
    ram_idx_t idx;
    word_t    data;
    word_t    rdata;
    begin_test("ram_readback");
    repeat (32) begin
      idx  = ram_idx_t'($urandom_range(`RAM_WORDS - 1));
      data = $urandom;
      bus_access(1'b1, ram_addr(idx), data, rdata);
      ram_model[idx] = data;
      written_q.push_back(idx);
      compare_word(32'h0, rdata);
    end
    foreach (written_q[i]) begin
      bus_access(1'b0, ram_addr(written_q[i]), '0, rdata);
      compare_word(ram_model[written_q[i]], rdata);
    end
    end_test();
  endtask

  task automatic gpio_loopback();
    word_t rdata;
    begin_test("gpio_loopback");
    gpio_out_exp = $urandom;
    gpio_en_exp  = $urandom;
    bus_access(1'b1, {`REGION_GPIO, 16'h0000}, gpio_out_exp, rdata);
    bus_access(1'b1, {`REGION_GPIO, 16'h0004}, gpio_en_exp, rdata);
    compare_word(gpio_out_exp, word_t'(gpio_o));
    compare_word(gpio_en_exp, word_t'(gpio_en_o));
    bus_access(1'b0, {`REGION_GPIO, 16'h0000}, '0, rdata);
    compare_word(gpio_out_exp, rdata);
    bus_access(1'b0, {`REGION_GPIO, 16'h0004}, '0, rdata);
    compare_word(gpio_en_exp, rdata);
    gpio_i = $urandom;
    // let the synchronizer settle
    repeat (4) @(negedge clk_i);
    bus_access(1'b0, {`REGION_GPIO, 16'h0008}, '0, rdata);
    compare_word(word_t'(gpio_i), rdata);
    bus_access(1'b0, {`REGION_GPIO, 16'h000C}, '0, rdata);
    compare_word(32'h0, rdata);
    end_test();
  endtask

  task automatic unmapped_access();
    word_t rdata;
    begin_test("unmapped_access");
    ram_model[1] = $urandom;
    bus_access(1'b1, ram_addr(ram_idx_t'(1)), ram_model[1], rdata);
    bus_access(1'b0, 32'h4000_0010, '0, rdata);
    compare_word(`UNMAPPED_RDATA, rdata);
    // low bits alias the GPIO output and the exit value
    bus_access(1'b1, 32'h4000_0000, $urandom | 32'h1, rdata);
    compare_word(32'h0, rdata);
    // low bits alias RAM word 1, the GPIO enable and the exit flag
    bus_access(1'b1, 32'h4000_0004, $urandom | 32'h1, rdata);
    compare_word(32'h0, rdata);
    compare_word(gpio_out_exp, word_t'(gpio_o));
    compare_word(gpio_en_exp, word_t'(gpio_en_o));
    compare_word(32'h0, exit_value_o);
    compare_word(32'h0, word_t'(exit_valid_o));
    bus_access(1'b0, ram_addr(ram_idx_t'(1)), '0, rdata);
    compare_word(ram_model[1], rdata);
    end_test();
  endtask

  task automatic exit_flag_sticky();
    word_t value;
    word_t rdata;
    begin_test("exit_flag_sticky");
    value = $urandom;
    bus_access(1'b1, {`REGION_SOC_CTRL, 16'h0000}, value, rdata);
    compare_word(value, exit_value_o);
    compare_word(32'h0, word_t'(exit_valid_o));
    bus_access(1'b1, {`REGION_SOC_CTRL, 16'h0004}, 32'h1, rdata);
    compare_word(32'h1, word_t'(exit_valid_o));
    bus_access(1'b1, {`REGION_SOC_CTRL, 16'h0004}, 32'h0, rdata);
    compare_word(32'h1, word_t'(exit_valid_o));
    bus_access(1'b0, {`REGION_SOC_CTRL, 16'h0004}, '0, rdata);
    compare_word(32'h1, rdata);
    end_test();
  endtask

  task automatic busy_drop();
    word_t first_val;
    word_t rdata;
    int    pulses;
    begin_test("busy_drop");
    first_val     = $urandom;
    ram_model[11] = $urandom;
    bus_access(1'b1, ram_addr(ram_idx_t'(11)), ram_model[11], rdata);
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_we_i    = 1'b1;
    bus_addr_i  = ram_addr(ram_idx_t'(10));
    bus_wdata_i = first_val;
    // second strobe lands while the controller is busy
    @(negedge clk_i);
    bus_addr_i  = ram_addr(ram_idx_t'(11));
    bus_wdata_i = ~ram_model[11];
    @(negedge clk_i);
    bus_req_i = 1'b0;
    pulses    = 0;
    repeat (8) begin
      if (bus_rvalid_o) pulses++;
      @(negedge clk_i);
    end
    compare_word(32'd1, word_t'(pulses));
    bus_access(1'b0, ram_addr(ram_idx_t'(10)), '0, rdata);
    compare_word(first_val, rdata);
    bus_access(1'b0, ram_addr(ram_idx_t'(11)), '0, rdata);
    compare_word(ram_model[11], rdata);
    end_test();
  endtask

  initial begin
    void'($urandom(32'h08641732));
    reset_i      = 1'b1;
    bus_req_i    = 1'b0;
    bus_we_i     = 1'b0;
    bus_addr_i   = '0;
    bus_wdata_i  = '0;
    gpio_i       = '0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    reset_state();
    ram_readback();
    gpio_loopback();
    unmapped_access();
    exit_flag_sticky();
    busy_drop();
    repeat (4) @(negedge clk_i);
    $display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, UUT.assert_i.fail_cnt);
    if (err_cnt == 0 && UUT.assert_i.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
logic/mini_mcu_pkg.sv
logic/bus_controller.sv
logic/ram_bank.sv
logic/gpio_unit.sv
logic/soc_ctrl.sv
logic/mini_mcu.sv
sim/mini_mcu_assert.sv
sim/tb_mini_mcu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the mini mcu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mini_mcu -f src.f -o tb_mini_mcu \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/tb_mini_mcu +verilator+error+limit+1000)"
echo "${sim_out}"
grep -q "NO ERRORS" <<< "${sim_out}" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
